// ==== common/rvseed_pkg.sv ====
package rvseed_pkg;

   // data and address width
   localparam int xlen = 64;

   // control-flow class handed over by decode
   typedef enum logic [2:0] {
      seq    = 3'd0,
      branch = 3'd1,
      jal    = 3'd2,
      jalr   = 3'd3,
      ebreak = 3'd4
   } flow_kind_e;

   // follows the riscv funct3 encoding
   typedef enum logic [2:0] {
      beq    = 3'b000,
      bne    = 3'b001,
      blt    = 3'b100,
      bge    = 3'b101,
      bltu   = 3'b110,
      bgeu   = 3'b111
   } br_op_e;

   // fetch sequencing states
   typedef enum logic [1:0] {
      run    = 2'd0,
      flush  = 2'd1,   // bubbles after a redirect
      halt   = 2'd2    // left only by reset
   } pc_state_e;

   // one record per decoded instruction, 198 bits
   typedef struct packed {
      flow_kind_e         kind;
      br_op_e             br_op;
      logic [xlen-1:0]    imm;       // already sign-extended
      logic [xlen-1:0]    rs1_val;
      logic [xlen-1:0]    rs2_val;
   } flow_ctrl_t;

endpackage

// ==== hw/branch_cmp.sv ====
`timescale 1ns/1ps

module branch_cmp (
   input  rvseed_pkg::flow_ctrl_t ctrl,
   output logic                   taken
);

   logic eq;
   logic lt_s;
   logic lt_u;
   logic cond;

   assign eq   = (ctrl.rs1_val == ctrl.rs2_val);
   assign lt_s = ($signed(ctrl.rs1_val) < $signed(ctrl.rs2_val));
   assign lt_u = (ctrl.rs1_val < ctrl.rs2_val);

   always_comb begin
      case (ctrl.br_op)
         rvseed_pkg::beq: begin
            cond = eq;
         end
         rvseed_pkg::bne: begin
            cond = !eq;
         end
         rvseed_pkg::blt: begin
            cond = lt_s;
         end
         rvseed_pkg::bge: begin
            cond = !lt_s;
         end
         rvseed_pkg::bltu: begin
            cond = lt_u;
         end
         rvseed_pkg::bgeu: begin
            cond = !lt_u;
         end
         default: begin
            cond = 1'b0;   // unused funct3 codes
         end
      endcase
   end

   assign taken = (ctrl.kind == rvseed_pkg::branch) && cond;

endmodule

// ==== hw/pc_gen.sv ====
`timescale 1ns/1ps

module pc_gen #(
   parameter logic [rvseed_pkg::xlen-1:0] RESET_PC    = 64'h0000_0000_8000_0000,
   parameter logic [rvseed_pkg::xlen-1:0] TRAP_VECTOR = 64'h0000_0000_8000_0000
) (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        accept,
   input  logic                        taken,
   input  rvseed_pkg::flow_ctrl_t      ctrl,
   output logic [rvseed_pkg::xlen-1:0] pc,
   output logic                        redirect,
   output logic                        trap
);

   localparam logic [rvseed_pkg::xlen-1:0] pc_step = 4;

   logic [rvseed_pkg::xlen-1:0] seq_pc;
   logic [rvseed_pkg::xlen-1:0] rel_pc;     // branch and jal target
   logic [rvseed_pkg::xlen-1:0] jalr_sum;
   logic [rvseed_pkg::xlen-1:0] next_pc;

   assign seq_pc   = pc + pc_step;
   assign rel_pc   = pc + ctrl.imm;
   assign jalr_sum = ctrl.rs1_val + ctrl.imm;

   always_comb begin
      next_pc  = seq_pc;
      redirect = 1'b0;
      trap     = 1'b0;
      case (ctrl.kind)
         rvseed_pkg::branch: begin
            if (taken) begin
               next_pc  = rel_pc;
               redirect = 1'b1;
            end
         end
         rvseed_pkg::jal: begin
            next_pc  = rel_pc;
            redirect = 1'b1;
         end
         rvseed_pkg::jalr: begin
            next_pc  = {jalr_sum[rvseed_pkg::xlen-1:1], 1'b0};   // lsb dropped per spec
            redirect = 1'b1;
         end
         rvseed_pkg::ebreak: begin
            next_pc  = TRAP_VECTOR;
            trap     = 1'b1;
         end
         default: begin
            next_pc  = seq_pc;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc <= RESET_PC;
      end else if (accept) begin
         pc <= next_pc;
      end
   end

   // adder check, jalr may legally produce a halfword address
   a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
      accept && ctrl.kind != rvseed_pkg::jalr && ctrl.imm[1:0] == 2'b00 && pc[1:0] == 2'b00
      |=> pc[1:0] == 2'b00)
      else $error("pc lost word alignment on a non-jalr path");

endmodule

// ==== hw/flush_timer.sv ====
`timescale 1ns/1ps

module flush_timer #(
   parameter int FLUSH_CYCLES = 2
) (
   input  logic clk,
   input  logic rst_n,
   input  logic start,
   output logic done
);

   logic [3:0] count;   // remaining bubble cycles

   if (FLUSH_CYCLES < 1 || FLUSH_CYCLES > 15) begin : g_bad_flush
      $error("FLUSH_CYCLES must be within 1..15");
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         count <= 4'd0;
      end else if (start) begin
         count <= 4'(FLUSH_CYCLES);
      end else if (count != 4'd0) begin
         count <= count - 4'd1;
      end
   end

   // last bubble, fsm returns to run on the next edge
   assign done = (count == 4'd1);

   a_no_restart: assert property (@(posedge clk) disable iff (!rst_n)
      start |-> count == 4'd0)
      else $error("flush timer restarted while still counting");

endmodule

// ==== hw/pc_ctrl_fsm.sv ====
`timescale 1ns/1ps

module pc_ctrl_fsm (
   input  logic clk,
   input  logic rst_n,
   input  logic instr_valid,
   input  logic redirect,
   input  logic trap,
   input  logic timer_done,
   output logic accept,
   output logic fetch_en,
   output logic halted,
   output logic timer_start
);

   rvseed_pkg::pc_state_e state;
   rvseed_pkg::pc_state_e state_nxt;

   assign fetch_en    = (state == rvseed_pkg::run);
   assign halted      = (state == rvseed_pkg::halt);
   assign accept      = instr_valid && fetch_en;   // strobes outside run are dropped
   assign timer_start = accept && redirect && !trap;

   always_comb begin
      state_nxt = state;
      case (state)
         rvseed_pkg::run: begin
            if (accept && trap) begin
               state_nxt = rvseed_pkg::halt;
            end else if (accept && redirect) begin
               state_nxt = rvseed_pkg::flush;
            end
         end
         rvseed_pkg::flush: begin
            if (timer_done) begin
               state_nxt = rvseed_pkg::run;
            end
         end
         rvseed_pkg::halt: begin
            state_nxt = rvseed_pkg::halt;   // only reset leaves
         end
         default: begin
            state_nxt = rvseed_pkg::run;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= rvseed_pkg::run;
      end else begin
         state <= state_nxt;
      end
   end

   // pc_gen flags at most one class per record
   a_one_class: assert property (@(posedge clk) disable iff (!rst_n)
      !(redirect && trap))
      else $error("redirect and trap raised together");

   // timer and fsm must agree on the bubble window
   a_done_in_flush: assert property (@(posedge clk) disable iff (!rst_n)
      timer_done |-> state == rvseed_pkg::flush)
      else $error("flush timer finished outside flush");

endmodule

// ==== hw/pc_unit.sv ====
`timescale 1ns/1ps

module pc_unit #(
   parameter logic [rvseed_pkg::xlen-1:0] RESET_PC     = 64'h0000_0000_8000_0000,
   parameter logic [rvseed_pkg::xlen-1:0] TRAP_VECTOR  = 64'h0000_0000_8000_0000,
   parameter int                          FLUSH_CYCLES = 2
) (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        instr_valid,
   input  rvseed_pkg::flow_ctrl_t      ctrl,
   output logic [rvseed_pkg::xlen-1:0] pc,
   output logic                        fetch_en,
   output logic                        halted
);

   logic accept;
   logic taken;
   logic redirect;
   logic trap;
   logic timer_start;
   logic timer_done;

   branch_cmp u_branch_cmp (
      .ctrl        (ctrl),
      .taken       (taken)
   );

   pc_gen #(
      .RESET_PC    (RESET_PC),
      .TRAP_VECTOR (TRAP_VECTOR)
   ) u_pc_gen (
      .clk         (clk),
      .rst_n       (rst_n),
      .accept      (accept),
      .taken       (taken),
      .ctrl        (ctrl),
      .pc          (pc),
      .redirect    (redirect),
      .trap        (trap)
   );

   flush_timer #(
      .FLUSH_CYCLES (FLUSH_CYCLES)
   ) u_flush_timer (
      .clk         (clk),
      .rst_n       (rst_n),
      .start       (timer_start),
      .done        (timer_done)
   );

   pc_ctrl_fsm u_pc_ctrl_fsm (
      .clk         (clk),
      .rst_n       (rst_n),
      .instr_valid (instr_valid),
      .redirect    (redirect),
      .trap        (trap),
      .timer_done  (timer_done),
      .accept      (accept),
      .fetch_en    (fetch_en),
      .halted      (halted),
      .timer_start (timer_start)
   );

endmodule

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int RESET_CYCLES = 8
) (
   input  logic reset_req,
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;   // 10 ns period
   end

   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 rst_n = 1'b1;
      forever begin
         @(posedge reset_req);   // later resets on request
         #1 rst_n = 1'b0;
         repeat (RESET_CYCLES) @(posedge clk);
         #1 rst_n = 1'b1;
      end
   end

endmodule

// ==== test/tb_pc_unit.sv ====
`timescale 1ns/1ps

module tb_pc_unit;

   localparam logic [63:0] RESET_PC      = 64'h0000_0000_8000_0000;
   localparam logic [63:0] TRAP_VECTOR   = 64'h0000_0000_8000_0000;
   localparam int          FLUSH_CYCLES  = 2;
   localparam int          FETCH_TIMEOUT = 20;
   localparam int          RESET_TIMEOUT = 40;

   typedef struct packed {
      logic [63:0] pc;
      logic        redirect;
      logic        trap;
   } expect_t;

   logic                   clk;
   logic                   rst_n;
   logic                   reset_req;
   logic                   instr_valid;
   rvseed_pkg::flow_ctrl_t ctrl;
   logic [63:0]            pc;
   logic                   fetch_en;
   logic                   halted;

   logic [63:0] m_pc;   // reference model state
   logic        m_fetch_en;
   logic        m_halted;
   int          m_bubbles;
   expect_t     m_next;
   logic [63:0] rng;
   int          errors;

   rvseed_pkg::br_op_e br_ops [6] = '{rvseed_pkg::beq, rvseed_pkg::bne, rvseed_pkg::blt,
                                      rvseed_pkg::bge, rvseed_pkg::bltu, rvseed_pkg::bgeu};

   tb_clock_gen clk_gen (
      .reset_req   (reset_req),
      .clk         (clk),
      .rst_n       (rst_n)
   );

   pc_unit dut (
      .clk         (clk),
      .rst_n       (rst_n),
      .instr_valid (instr_valid),
      .ctrl        (ctrl),
      .pc          (pc),
      .fetch_en    (fetch_en),
      .halted      (halted)
   );

   function automatic logic [63:0] next_rand();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 7);
      rng = rng ^ (rng << 17);
      return rng;
   endfunction

   // corner values mixed with plain random ones
   function automatic logic [63:0] pick_operand(input logic [63:0] r);
      case (r[2:0])
         3'd0: return 64'd0;
         3'd1: return {64{1'b1}};
         3'd2: return 64'h8000_0000_0000_0000;
         3'd3: return 64'h7fff_ffff_ffff_ffff;
         3'd4: return {61'd0, r[5:3]};
         3'd5: return {{60{1'b1}}, r[6:3]};   // small negative
         default: return r;
      endcase
   endfunction

   function automatic string state_text(input rvseed_pkg::pc_state_e s);
      case (s)
         rvseed_pkg::run:   return "run";
         rvseed_pkg::flush: return "flush";
         rvseed_pkg::halt:  return "halt";
         default:           return "unknown";
      endcase
   endfunction

   function automatic expect_t expect_next(input logic [63:0] cur_pc,
                                           input rvseed_pkg::flow_ctrl_t c);
      expect_t     e;
      logic        cond;
      logic        lt_u;
      logic        lt_s;
      logic [63:0] sum;
      e.pc       = cur_pc + 64'd4;
      e.redirect = 1'b0;
      e.trap     = 1'b0;
      lt_u = c.rs1_val < c.rs2_val;
      lt_s = (c.rs1_val[63] != c.rs2_val[63]) ? c.rs1_val[63] : lt_u;   // sign decides first
      case (c.br_op)
         rvseed_pkg::beq:  cond = (c.rs1_val == c.rs2_val);
         rvseed_pkg::bne:  cond = (c.rs1_val != c.rs2_val);
         rvseed_pkg::blt:  cond = lt_s;
         rvseed_pkg::bge:  cond = !lt_s;
         rvseed_pkg::bltu: cond = lt_u;
         rvseed_pkg::bgeu: cond = !lt_u;
         default:          cond = 1'b0;
      endcase
      sum = c.rs1_val + c.imm;
      if (c.kind == rvseed_pkg::branch && cond || c.kind == rvseed_pkg::jal) begin
         e.pc       = cur_pc + c.imm;
         e.redirect = 1'b1;
      end else if (c.kind == rvseed_pkg::jalr) begin
         e.pc       = sum & ~64'd1;
         e.redirect = 1'b1;
      end else if (c.kind == rvseed_pkg::ebreak) begin
         e.pc   = TRAP_VECTOR;
         e.trap = 1'b1;
      end
      return e;
   endfunction

   task automatic abort_run();
      errors++;
      $display("Done: errors found");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic fail_check(input string msg);
      $display("CHECK FAILED at %0t ns: %s", $time, msg);
      abort_run();
   endtask

   task automatic fetch_timeout();
      $display("fetch_en never returned within %0d cycles", FETCH_TIMEOUT);
      abort_run();
   endtask

   // model follows the inputs seen at each edge
   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         m_pc       <= RESET_PC;
         m_fetch_en <= 1'b1;
         m_halted   <= 1'b0;
         m_bubbles  <= 0;
      end else if (m_halted) begin
         m_fetch_en <= 1'b0;
      end else if (m_bubbles != 0) begin
         m_bubbles <= m_bubbles - 1;
         if (m_bubbles == 1) begin
            m_fetch_en <= 1'b1;
         end
      end else if (instr_valid) begin
         m_next = expect_next(m_pc, ctrl);
         m_pc   <= m_next.pc;
         if (m_next.trap) begin
            m_halted   <= 1'b1;
            m_fetch_en <= 1'b0;
         end else if (m_next.redirect) begin
            m_fetch_en <= 1'b0;
            m_bubbles  <= FLUSH_CYCLES;
         end
      end
   end

   always @(negedge clk) begin
      if (rst_n === 1'b1) begin
         assert (pc === m_pc)
            else fail_check($sformatf("pc %h, expected %h, state %s", pc, m_pc,
                                      state_text(dut.u_pc_ctrl_fsm.state)));
         assert (fetch_en === m_fetch_en)
            else fail_check($sformatf("fetch_en %b, expected %b, state %s", fetch_en,
                                      m_fetch_en, state_text(dut.u_pc_ctrl_fsm.state)));
         assert (halted === m_halted)
            else fail_check($sformatf("halted %b, expected %b", halted, m_halted));
      end
   end

   task automatic wait_reset_release();
      int waited;
      waited = 0;
      while (rst_n !== 1'b1) begin
         if (waited >= RESET_TIMEOUT) begin
            $display("rst_n was never released");
            abort_run();
         end
         @(negedge clk);
         waited++;
      end
      @(posedge clk);
      #1;
   endtask

   task automatic issue(input rvseed_pkg::flow_ctrl_t c);
      int waited;
      waited = 0;
      while (fetch_en !== 1'b1) begin
         if (waited >= FETCH_TIMEOUT) begin
            fetch_timeout();
         end
         @(posedge clk);
         #1;
         waited++;
      end
      instr_valid = 1'b1;
      ctrl        = c;
      @(posedge clk);
      #1;
      instr_valid = 1'b0;
   endtask

   // strobes a jal through the bubbles, which must be dropped
   task automatic issue_redirect(input rvseed_pkg::flow_ctrl_t c);
      rvseed_pkg::flow_ctrl_t filler;
      int                     bubbles;
      filler      = '0;
      filler.kind = rvseed_pkg::jal;
      filler.imm  = 64'h40;
      bubbles     = 0;
      issue(c);
      while (fetch_en !== 1'b1) begin
         if (bubbles >= FETCH_TIMEOUT) begin
            fetch_timeout();
         end
         instr_valid = 1'b1;
         ctrl        = filler;
         @(posedge clk);
         #1;
         bubbles++;
      end
      instr_valid = 1'b0;
      assert (bubbles == FLUSH_CYCLES)
         else fail_check($sformatf("fetch_en low for %0d cycles, expected %0d",
                                   bubbles, FLUSH_CYCLES));
   endtask

   task automatic run_sequential(input int count);
      rvseed_pkg::flow_ctrl_t c;
      c = '0;
      c.kind = rvseed_pkg::seq;
      for (int i = 0; i < count; i++) begin
         issue(c);
      end
   endtask

   task automatic check_reset_state();
      assert (pc === RESET_PC && fetch_en === 1'b1 && halted === 1'b0)
         else fail_check($sformatf("after reset pc %h fetch_en %b halted %b",
                                   pc, fetch_en, halted));
   endtask

   initial begin
      rvseed_pkg::flow_ctrl_t c;
      expect_t                e;
      logic [63:0]            r;
      int                     waited;
      rng         = 64'd77;
      errors      = 0;
      reset_req   = 1'b0;
      instr_valid = 1'b0;
      ctrl        = '0;
      wait_reset_release();
      check_reset_state();
      run_sequential(6);

      for (int i = 0; i < 60; i++) begin
         r         = next_rand();
         c         = '0;
         c.kind    = rvseed_pkg::branch;
         c.br_op   = br_ops[i % 6];
         c.rs1_val = pick_operand(next_rand());
         c.rs2_val = (r[3:2] == 2'b00) ? c.rs1_val : pick_operand(next_rand());
         c.imm     = {{51{r[63]}}, r[62:52], 2'b00};   // word aligned offset
         e         = expect_next(m_pc, c);
         if (e.redirect) begin
            issue_redirect(c);
         end else begin
            issue(c);
            assert (fetch_en === 1'b1)
               else fail_check("non-taken branch dropped fetch_en");
         end
      end

      for (int i = 0; i < 20; i++) begin
         r         = next_rand();
         c         = '0;
         c.kind    = i[0] ? rvseed_pkg::jalr : rvseed_pkg::jal;
         c.rs1_val = next_rand();
         c.imm     = i[0] ? {{52{r[11]}}, r[11:0]} : {{51{r[63]}}, r[62:52], 2'b00};
         issue_redirect(c);
         run_sequential(2);
      end

      c      = '0;
      c.kind = rvseed_pkg::ebreak;
      issue(c);
      assert (pc === TRAP_VECTOR && halted === 1'b1)
         else fail_check($sformatf("ebreak left pc %h halted %b", pc, halted));
      for (int i = 0; i < 12; i++) begin
         instr_valid = 1'b1;
         ctrl        = '0;
         ctrl.kind   = (i % 2 == 0) ? rvseed_pkg::seq : rvseed_pkg::jal;
         ctrl.imm    = 64'h100;
         @(posedge clk);
         #1;
         assert (fetch_en === 1'b0 && halted === 1'b1)
            else fail_check("fetch resumed after ebreak");
      end
      instr_valid = 1'b0;

      reset_req = 1'b1;
      waited    = 0;
      while (rst_n !== 1'b0) begin
         if (waited >= RESET_TIMEOUT) begin
            $display("rst_n was never asserted again");
            abort_run();
         end
         @(negedge clk);
         waited++;
      end
      reset_req = 1'b0;
      wait_reset_release();
      check_reset_state();
      run_sequential(4);

      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

// ==== build.f ====
common/rvseed_pkg.sv
hw/branch_cmp.sv
hw/pc_gen.sv
hw/flush_timer.sv
hw/pc_ctrl_fsm.sv
hw/pc_unit.sv
test/tb_clock_gen.sv
test/tb_pc_unit.sv
